/* rtl/stream_sink_settings.svh */
// Stream sink settings
`ifndef STREAM_SINK_SETTINGS_SVH
`define STREAM_SINK_SETTINGS_SVH

// Memory address width in bits
`define SINK_ADDR_WIDTH 32

// Width of one lane word on the memory side
`define SINK_DATA_WIDTH 32

// Byte enables per lane word
`define SINK_BE_WIDTH 4

// Lanes per stream beat, one memory port each
`define SINK_NPX 4

// Register index width of the configuration port
`define SINK_CFG_ADDR_WIDTH 2

`endif

/* rtl/stream_sink_pkg.sv */
// Stream sink types
`include "stream_sink_settings.svh"

package stream_sink_pkg;

  // Configuration register map
  typedef enum logic [`SINK_CFG_ADDR_WIDTH-1:0] {
    REG_BASE = 2'd0,
    REG_GEOM = 2'd1,
    REG_CTRL = 2'd2
  } cfg_reg_e;

  // Lane payload, byte enables and address
  typedef logic [`SINK_DATA_WIDTH-1:0] lane_word_t;
  typedef logic [`SINK_BE_WIDTH-1:0]   lane_be_t;
  typedef logic [`SINK_ADDR_WIDTH-1:0] mem_addr_t;

  // Halves of a geometry word
  localparam int GEOM_BEATS  = 1;
  localparam int GEOM_STRIDE = 0;

  // Go bit of a control word
  localparam int CTRL_GO_BIT = 0;

  // One configuration word, seen either as a full address
  // or as a beat count over a byte stride
  typedef union packed {
    mem_addr_t                                 addr;
    logic [1:0][`SINK_DATA_WIDTH/2-1:0] geom;
  } cfg_word_u;

endpackage

/* rtl/sink_cfg_regs.sv */
// Sink configuration registers
`timescale 1ns/1ps
`include "stream_sink_settings.svh"

module sink_cfg_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cfg_we_i,
  input  stream_sink_pkg::cfg_reg_e   cfg_addr_i,
  input  stream_sink_pkg::cfg_word_u  cfg_wdata_i,
  output stream_sink_pkg::mem_addr_t  base_o,
  output stream_sink_pkg::cfg_word_u  geom_o,
  output logic                        start_o
);
  import stream_sink_pkg::*;

  mem_addr_t base_q;
  cfg_word_u geom_q;
  logic      start_q;
  logic      go_wr;

  // Control write with the go bit set
  assign go_wr = cfg_we_i && (cfg_addr_i == REG_CTRL) && cfg_wdata_i.addr[CTRL_GO_BIT];

  // Base and geometry registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_q <= '0;
      geom_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        // Whole word taken as an address
        REG_BASE: base_q <= cfg_wdata_i.addr;
        // Count and stride stay packed for the address generator
        REG_GEOM: geom_q <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Start pulse one cycle after the control write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= go_wr;
    end
  end

  assign base_o  = base_q;
  assign geom_o  = geom_q;
  assign start_o = start_q;

  // Start is a single-cycle pulse
  a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    start_o |=> !start_o);

endmodule

/* rtl/sink_addressgen.sv */
// Sink beat address generator
`timescale 1ns/1ps
`include "stream_sink_settings.svh"

module sink_addressgen (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic                        busy_i,
  input  logic                        beat_acc_i,
  input  stream_sink_pkg::mem_addr_t  base_i,
  input  stream_sink_pkg::cfg_word_u  geom_i,
  output stream_sink_pkg::mem_addr_t  beat_addr_o,
  output logic                        last_beat_o
);
  import stream_sink_pkg::*;

  // Beat counter width matches one geometry half
  localparam int CNT_W = `SINK_DATA_WIDTH / 2;

  mem_addr_t        addr_q;
  mem_addr_t        stride_q;
  logic [CNT_W-1:0] beats_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] beats_cfg;
  logic             job_start;

  // Start only counts while no job runs
  assign job_start = start_i && !busy_i;

  // Requested beat count from the geometry word
  assign beats_cfg = geom_i.geom[GEOM_BEATS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q   <= '0;
      stride_q <= '0;
      beats_q  <= '0;
      cnt_q    <= '0;
    end else if (job_start) begin
      // Snapshot of the job geometry
      addr_q   <= base_i;
      stride_q <= mem_addr_t'(geom_i.geom[GEOM_STRIDE]);
      // Zero beats runs as a single beat
      beats_q  <= (beats_cfg == '0) ? CNT_W'(1) : beats_cfg;
      cnt_q    <= '0;
    end else if (beat_acc_i) begin
      // Step to the next beat
      addr_q   <= addr_q + stride_q;
      cnt_q    <= cnt_q + 1'b1;
    end
  end

  assign beat_addr_o = addr_q;

  // Current beat is the final one of the job
  assign last_beat_o = (cnt_q == beats_q - 1'b1);

  // Beats are only accepted during a running job
  a_acc_busy: assert property (@(posedge clk) disable iff (!rst_n)
    beat_acc_i |-> busy_i);

endmodule

/* rtl/stream_sink.sv */
// Stream to memory sink
`timescale 1ns/1ps
`include "stream_sink_settings.svh"

module stream_sink (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         start_i,
  // Stream input
  input  logic                                         tvalid_i,
  output logic                                         tready_o,
  input  stream_sink_pkg::lane_word_t [`SINK_NPX-1:0]  tdata_i,
  input  stream_sink_pkg::lane_be_t   [`SINK_NPX-1:0]  tstrb_i,
  // Address generator side
  input  stream_sink_pkg::mem_addr_t                   beat_addr_i,
  input  logic                                         last_beat_i,
  output logic                                         beat_acc_o,
  // Job status
  output logic                                         busy_o,
  output logic                                         done_o,
  // Memory ports, one per lane
  output logic                        [`SINK_NPX-1:0]  tcdm_req_o,
  input  logic                        [`SINK_NPX-1:0]  tcdm_gnt_i,
  output stream_sink_pkg::mem_addr_t  [`SINK_NPX-1:0]  tcdm_add_o,
  output stream_sink_pkg::lane_be_t   [`SINK_NPX-1:0]  tcdm_be_o,
  output stream_sink_pkg::lane_word_t [`SINK_NPX-1:0]  tcdm_data_o
);
  import stream_sink_pkg::*;

  typedef enum logic {
    IDLE,
    SINK
  } sink_state_e;

  sink_state_e state_q;
  sink_state_e state_d;
  logic        lane_req;
  logic        done_q;
  logic        done_d;

  // All lanes request together while a beat is offered
  assign lane_req = (state_q == SINK) && tvalid_i;

  // Lane fan-out of the current beat
  for (genvar j = 0; j < `SINK_NPX; j++) begin : g_lane
    assign tcdm_req_o[j]  = lane_req;
    // Lanes sit on consecutive words of the beat
    assign tcdm_add_o[j]  = beat_addr_i + mem_addr_t'(j * `SINK_BE_WIDTH);
    assign tcdm_be_o[j]   = tstrb_i[j];
    assign tcdm_data_o[j] = tdata_i[j];
  end

  // Beat goes only once every lane is granted
  assign tready_o   = &(tcdm_req_o & tcdm_gnt_i);
  assign beat_acc_o = tvalid_i && tready_o;

  // Next state and end of job
  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = SINK;
        end
      end
      SINK: begin
        // Final beat accepted
        if (beat_acc_o && last_beat_i) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  assign busy_o = (state_q == SINK);
  assign done_o = done_q;

  // No memory traffic outside a job
  a_idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) |-> (tcdm_req_o == '0));

  // Ready only with every lane granted
  a_ready_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    tready_o |-> (&tcdm_gnt_i));

  // A stalled beat keeps its address
  a_stall_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_o && tvalid_i && !tready_o) |=> $stable(beat_addr_i));

endmodule

/* rtl/stream_sink_top.sv */
// Stream sink top level
`timescale 1ns/1ps
`include "stream_sink_settings.svh"

module stream_sink_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  // Configuration writes
  input  logic                                         cfg_we_i,
  input  stream_sink_pkg::cfg_reg_e                    cfg_addr_i,
  input  stream_sink_pkg::cfg_word_u                   cfg_wdata_i,
  // Stream input
  input  logic                                         tvalid_i,
  output logic                                         tready_o,
  input  stream_sink_pkg::lane_word_t [`SINK_NPX-1:0]  tdata_i,
  input  stream_sink_pkg::lane_be_t   [`SINK_NPX-1:0]  tstrb_i,
  // Memory ports
  output logic                        [`SINK_NPX-1:0]  tcdm_req_o,
  input  logic                        [`SINK_NPX-1:0]  tcdm_gnt_i,
  output stream_sink_pkg::mem_addr_t  [`SINK_NPX-1:0]  tcdm_add_o,
  output stream_sink_pkg::lane_be_t   [`SINK_NPX-1:0]  tcdm_be_o,
  output stream_sink_pkg::lane_word_t [`SINK_NPX-1:0]  tcdm_data_o,
  // Job status
  output logic                                         busy_o,
  output logic                                         done_o
);
  import stream_sink_pkg::*;

  mem_addr_t base;
  cfg_word_u geom;
  mem_addr_t beat_addr;
  logic      start;
  logic      last_beat;
  logic      beat_acc;

  sink_cfg_regs u_cfg_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .base_o      (base),
    .geom_o      (geom),
    .start_o     (start)
  );

  // Busy from the sink blocks restarts in the generator
  sink_addressgen u_addressgen (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .busy_i      (busy_o),
    .beat_acc_i  (beat_acc),
    .base_i      (base),
    .geom_i      (geom),
    .beat_addr_o (beat_addr),
    .last_beat_o (last_beat)
  );

  stream_sink u_sink (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .tvalid_i    (tvalid_i),
    .tready_o    (tready_o),
    .tdata_i     (tdata_i),
    .tstrb_i     (tstrb_i),
    .beat_addr_i (beat_addr),
    .last_beat_i (last_beat),
    .beat_acc_o  (beat_acc),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .tcdm_req_o  (tcdm_req_o),
    .tcdm_gnt_i  (tcdm_gnt_i),
    .tcdm_add_o  (tcdm_add_o),
    .tcdm_be_o   (tcdm_be_o),
    .tcdm_data_o (tcdm_data_o)
  );

endmodule

/* tests/tb_sink_model.svh */
// Sink testbench model
`ifndef TB_SINK_MODEL_SVH
`define TB_SINK_MODEL_SVH

// Fibonacci LFSR state, taps 32 22 2 1
logic [31:0] lfsr_q;

// Expected lane writes of one accepted beat
mem_addr_t  exp_add  [`SINK_NPX];
lane_word_t exp_data [`SINK_NPX];
lane_be_t   exp_be   [`SINK_NPX];

// One LFSR step per returned bit, newest bit lowest
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  int          i;
  val = '0;
  for (i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// Lane j of beat k lands at base + k * stride + 4 * j
task automatic model_beat(input mem_addr_t base, input mem_addr_t stride, input int k,
                          input lane_word_t [`SINK_NPX-1:0] data,
                          input lane_be_t [`SINK_NPX-1:0] strb);
  int j;
  for (j = 0; j < `SINK_NPX; j++) begin
    exp_add[j]  = base + stride * mem_addr_t'(k) + mem_addr_t'(4 * j);
    exp_data[j] = data[j];
    // Byte enables straight from the stream strobes
    exp_be[j]   = strb[j];
  end
endtask

task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
  if (got !== exp) report_error($sformatf("%s: got %h, expected %h", what, got, exp));
endtask

task automatic check_word(input string what, input lane_word_t got, input lane_word_t exp);
  if (got !== exp) report_error($sformatf("%s: got %h, expected %h", what, got, exp));
endtask

task automatic check_be(input string what, input lane_be_t got, input lane_be_t exp);
  if (got !== exp) report_error($sformatf("%s: got %b, expected %b", what, got, exp));
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp) report_error($sformatf("%s: got %b, expected %b", what, got, exp));
endtask

`endif

/* tests/tb_stream_sink.sv */
// Stream sink testbench
`timescale 1ns/1ps
`include "stream_sink_settings.svh"

module tb_stream_sink;
  import stream_sink_pkg::*;

  localparam int NUM_JOBS       = 20;
  localparam int MAX_BEATS      = 12;
  localparam int TIMEOUT_CYCLES = NUM_JOBS * (MAX_BEATS * 16 + 32);

  logic                        clk;
  logic                        rst_n;
  logic                        cfg_we;
  cfg_reg_e                    cfg_addr;
  cfg_word_u                   cfg_wdata;
  logic                        tvalid;
  logic                        tready;
  lane_word_t [`SINK_NPX-1:0]  tdata;
  lane_be_t   [`SINK_NPX-1:0]  tstrb;
  logic       [`SINK_NPX-1:0]  tcdm_req;
  logic       [`SINK_NPX-1:0]  tcdm_gnt;
  mem_addr_t  [`SINK_NPX-1:0]  tcdm_add;
  lane_be_t   [`SINK_NPX-1:0]  tcdm_be;
  lane_word_t [`SINK_NPX-1:0]  tcdm_data;
  logic                        busy;
  logic                        done;

  // Expected sink state and configuration registers
  logic        exp_busy;
  logic        exp_done;
  logic        exp_start;
  mem_addr_t   reg_base;
  logic [31:0] reg_geom;
  // Geometry of the running job
  mem_addr_t   job_base;
  mem_addr_t   job_stride;
  int          job_beats;
  int          beat_k;
  int          cyc_cnt;

  `include "tb_sink_model.svh"

  stream_sink_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .tvalid_i    (tvalid),
    .tready_o    (tready),
    .tdata_i     (tdata),
    .tstrb_i     (tstrb),
    .tcdm_req_o  (tcdm_req),
    .tcdm_gnt_i  (tcdm_gnt),
    .tcdm_add_o  (tcdm_add),
    .tcdm_be_o   (tcdm_be),
    .tcdm_data_o (tcdm_data),
    .busy_o      (busy),
    .done_o      (done)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
  endtask

  // Cycle limit scaled by job count and beat length
  always @(posedge clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Run timed out after %0d cycles with jobs unfinished", cyc_cnt));
    end
  end

  // New job geometry of 0 to 12 beats and stride 16 to 64 bytes
  task automatic pick_job(output mem_addr_t base, output logic [31:0] geom);
    logic [31:0] beats;
    logic [31:0] stride;
    logic [31:0] raw;
    beats  = rand_bits(4) % 32'd13;
    stride = (rand_bits(4) % 32'd13 + 32'd4) << 2;
    raw    = rand_bits(30);
    base   = {raw[29:0], 2'b00};
    geom   = {beats[15:0], stride[15:0]};
  endtask

  // Drive on the falling edge and check 2 ns ahead of the rising edge
  task automatic run_cycle(input logic we, input cfg_reg_e addr, input logic [31:0] wdata);
    logic        acc;
    logic        last;
    logic [31:0] raw;
    int          j;
    @(negedge clk);
    cfg_we         = we;
    cfg_addr       = addr;
    cfg_wdata.addr = wdata;
    tvalid         = |rand_bits(2);
    for (j = 0; j < `SINK_NPX; j++) begin
      tdata[j]    = rand_bits(32);
      raw         = rand_bits(4);
      tstrb[j]    = raw[3:0];
      // Each lane granted three times in four
      tcdm_gnt[j] = |rand_bits(2);
    end
    #2;
    acc = exp_busy && tvalid && (&tcdm_gnt);
    check_flag("tready_o", tready, acc);
    check_flag("busy_o", busy, exp_busy);
    check_flag("done_o", done, exp_done);
    for (j = 0; j < `SINK_NPX; j++) begin
      check_flag($sformatf("tcdm_req_o[%0d]", j), tcdm_req[j], exp_busy && tvalid);
    end
    if (acc) begin
      model_beat(job_base, job_stride, beat_k, tdata, tstrb);
      for (j = 0; j < `SINK_NPX; j++) begin
        check_addr($sformatf("beat %0d tcdm_add_o[%0d]", beat_k, j), tcdm_add[j], exp_add[j]);
        check_word($sformatf("beat %0d tcdm_data_o[%0d]", beat_k, j), tcdm_data[j], exp_data[j]);
        check_be($sformatf("beat %0d tcdm_be_o[%0d]", beat_k, j), tcdm_be[j], exp_be[j]);
      end
    end
    // State after the coming rising edge
    last     = acc && (beat_k == job_beats - 1);
    exp_done = last;
    if (exp_busy) begin
      exp_busy = !last;
      if (acc) beat_k++;
    end else if (exp_start) begin
      // Job geometry taken from the registers at start
      exp_busy   = 1'b1;
      job_base   = reg_base;
      job_stride = {16'h0, reg_geom[15:0]};
      job_beats  = (reg_geom[31:16] == 16'h0) ? 1 : int'(reg_geom[31:16]);
      beat_k     = 0;
    end
    exp_start = we && (addr == REG_CTRL) && wdata[0];
    if (we && (addr == REG_BASE)) reg_base = wdata;
    if (we && (addr == REG_GEOM)) reg_geom = wdata;
  endtask

  initial begin
    mem_addr_t   nxt_base;
    logic [31:0] nxt_geom;
    logic        prewritten;
    int          step;
    int          job;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = REG_BASE;
    cfg_wdata  = '0;
    tvalid     = 1'b0;
    tdata      = '0;
    tstrb      = '0;
    tcdm_gnt   = '0;
    lfsr_q     = 32'h8e560ab1;
    cyc_cnt    = 0;
    exp_busy   = 1'b0;
    exp_done   = 1'b0;
    exp_start  = 1'b0;
    reg_base   = '0;
    reg_geom   = '0;
    job_base   = '0;
    job_stride = '0;
    job_beats  = 1;
    beat_k     = 0;
    prewritten = 1'b0;
    nxt_base   = '0;
    nxt_geom   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet sink after reset despite stream traffic
    repeat (4) run_cycle(1'b0, REG_BASE, 32'h0);
    for (job = 0; job < NUM_JOBS; job++) begin
      if (!prewritten) begin
        pick_job(nxt_base, nxt_geom);
        // First job asks for zero beats
        if (job == 0) nxt_geom[31:16] = 16'h0;
        run_cycle(1'b1, REG_BASE, nxt_base);
        run_cycle(1'b1, REG_GEOM, nxt_geom);
      end
      prewritten = 1'b0;
      run_cycle(1'b1, REG_CTRL, 32'h1);
      step = 0;
      while (exp_busy || exp_start) begin
        // Every third job gets the next setup and a stray go mid-run
        if ((job % 3 == 1) && exp_busy && step == 0) begin
          pick_job(nxt_base, nxt_geom);
          run_cycle(1'b1, REG_BASE, nxt_base);
          step = 1;
        end else if (exp_busy && step == 1) begin
          run_cycle(1'b1, REG_GEOM, nxt_geom);
          prewritten = 1'b1;
          step = 2;
        end else if (exp_busy && step == 2 && (job_beats - beat_k >= 2)) begin
          // Start pulse lands while at least one beat is left
          run_cycle(1'b1, REG_CTRL, 32'h1);
          step = 3;
        end else begin
          run_cycle(1'b0, REG_BASE, 32'h0);
        end
      end
      // Done pulse with busy low and then done gone
      run_cycle(1'b0, REG_BASE, 32'h0);
      run_cycle(1'b0, REG_BASE, 32'h0);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

/* stream_sink.f */
+incdir+rtl
+incdir+tests
rtl/stream_sink_pkg.sv
rtl/sink_cfg_regs.sv
rtl/sink_addressgen.sv
rtl/stream_sink.sv
rtl/stream_sink_top.sv
tests/tb_stream_sink.sv

/* Makefile */
# Verilator simulation of the stream sink
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_stream_sink
FILELIST  := stream_sink.f
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
